/* all.f */
common/radio_pkg.sv
design/timekeeper.sv
radio_core/rx_sample_fifo.sv
radio_core/radio_core.sv
design/pkt_arbiter.sv
design/radio_block.sv
verification/pkt_arbiter_asserts.sv
verification/radio_block_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the radio block testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f all.f --top-module radio_block_tb \
  -o radio_block_sim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/radio_block_sim > sim.log 2>&1
cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1
grep -q "STATUS: PASS" sim.log || exit 1
exit 0

/* verification/radio_block_tb.sv */
/*
 * Radio block testbench
 * Directed tests of framing, timestamps, PPS load, arbitration and overflow
 */
`timescale 1ns/1ps

module radio_block_tb;

  import radio_pkg::*;

  localparam int CLK_PERIOD  = 20;
  // Five tests of well under two hundred cycles each
  localparam int TEST_CYCLES = 1000;
  localparam int TIMEOUT_NS  = TEST_CYCLES * CLK_PERIOD;

  logic                     ce_clk;
  logic                     i_rst_n;
  settings_bus_t            set_bus;
  logic                     pps;
  sample_t [NUM_RADIOS-1:0] rx;
  logic [NUM_RADIOS-1:0]    rx_stb;
  logic                     out_ready;
  stream_beat_t             beat;
  logic                     tvalid;
  vita_time_t               lastpps;
  logic [NUM_RADIOS-1:0]    overflow;

  int           cyc;
  int           wr_cyc;
  int           stb_cyc;
  stream_beat_t mon_q [$];
  stream_beat_t pkt_q [$];
  sample_t      exp_q [NUM_RADIOS][$];
  seqnum_t      exp_seq [NUM_RADIOS];

  radio_block DUT (
    .ce_clk              (ce_clk),
    .i_rst_n             (i_rst_n),
    .i_set               (set_bus),
    .i_pps               (pps),
    .i_rx                (rx),
    .i_rx_stb            (rx_stb),
    .i_o_tready          (out_ready),
    .o_beat              (beat),
    .o_tvalid            (tvalid),
    .o_vita_time_lastpps (lastpps),
    .o_rx_overflow       (overflow)
  );

  always #(CLK_PERIOD / 2) ce_clk = ~ce_clk;

  // Cycle counter and output beat monitor
  always @(posedge ce_clk) begin
    cyc = cyc + 1;
    if (i_rst_n && tvalid && out_ready) begin
      mon_q.push_back(beat);
    end
  end

  task automatic report_failure(input string line);
    $display("%s", line);
    $display("STATUS: FAIL");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
      report_failure($sformatf("CHECK FAILED: %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_time(input string name, input vita_time_t exp, input vita_time_t act);
    if (exp !== act) begin
      report_failure($sformatf("CHECK FAILED: %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      report_failure($sformatf("CHECK FAILED: %s expected %b actual %b", name, exp, act));
    end
  endtask

  task automatic next_cycle();
    @(posedge ce_clk);
    #1;
  endtask

  // One settings write that records its cycle in wr_cyc
  task automatic set_write(input set_addr_t addr, input set_data_t data);
    wr_cyc  = cyc;
    set_bus = '{stb: 1'b1, addr: addr, data: data};
    next_cycle();
    set_bus.stb = 1'b0;
  endtask

  function automatic set_addr_t radio_addr(input int r, input int off);
    return set_addr_t'(int'(SR_RADIO_BASE) + 8 * r + off);
  endfunction

  task automatic config_radio(input int r, input int spp);
    set_write(radio_addr(r, SR_RX_SPP), set_data_t'(spp));
    set_write(radio_addr(r, SR_RX_ENABLE), 32'd1);
  endtask

  task automatic disable_radio(input int r);
    set_write(radio_addr(r, SR_RX_ENABLE), 32'd0);
    exp_seq[r] = '0;
  endtask

  task automatic load_time_now(input vita_time_t t);
    set_write(SR_TIME_HI, t[63:32]);
    set_write(SR_TIME_LO, t[31:0]);
    set_write(SR_TIME_CTRL, 32'h1);
  endtask

  // Strobes count random samples back to back on every radio in mask
  task automatic strobe_samples(input logic [NUM_RADIOS-1:0] mask, input int count);
    sample_t s;
    stb_cyc = cyc;
    for (int i = 0; i < count; i++) begin
      for (int r = 0; r < NUM_RADIOS; r++) begin
        if (mask[r]) begin
          s     = $urandom;
          rx[r] = s;
          exp_q[r].push_back(s);
        end
      end
      rx_stb = mask;
      next_cycle();
    end
    rx_stb = '0;
  endtask

  task automatic collect_packet();
    stream_beat_t b;
    logic         done;
    pkt_q.delete();
    done = 1'b0;
    while (!done) begin
      while (mon_q.size() == 0) begin
        next_cycle();
      end
      b = mon_q.pop_front();
      pkt_q.push_back(b);
      done = b.tlast;
    end
    next_cycle();
  endtask

  function automatic word_t make_header(input int r, input seqnum_t seq, input spp_t spp);
    word_t h;
    h = '0;
    h[HDR_RADIO_LSB +: 8] = 8'(r);
    h[HDR_SEQ_LSB +: 8]   = seq;
    h[HDR_SPP_LSB +: 8]   = spp;
    return h;
  endfunction

  task automatic verify_packet(input string name, input int r, input spp_t spp,
                               input logic ts_chk, input vita_time_t ts);
    sample_t s;
    if (pkt_q.size() != int'(spp) + 2) begin
      report_failure($sformatf("%s: packet has %0d beats but %0d were expected",
                               name, pkt_q.size(), int'(spp) + 2));
    end
    check_word({name, " header"}, make_header(r, exp_seq[r], spp), pkt_q[0].tdata);
    check_bit({name, " header tlast"}, 1'b0, pkt_q[0].tlast);
    if (ts_chk) begin
      check_time({name, " timestamp"}, ts, pkt_q[1].tdata);
    end
    for (int i = 0; i < int'(spp); i++) begin
      s = exp_q[r].pop_front();
      check_word($sformatf("%s sample %0d", name, i), {32'd0, s}, pkt_q[i + 2].tdata);
      check_bit($sformatf("%s tlast %0d", name, i), i == int'(spp) - 1, pkt_q[i + 2].tlast);
    end
    exp_seq[r] = exp_seq[r] + 1'b1;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////
  task automatic test_single_packet();
    config_radio(0, 4);
    strobe_samples(2'b01, 4);
    collect_packet();
    verify_packet("single packet", 0, 8'd4, 1'b0, '0);
  endtask

  // Load in cycle c gives T in c+1, so a strobe in cycle s sees T+s-c-1
  task automatic test_timestamp();
    vita_time_t t;
    int         c;
    t = {$urandom, $urandom};
    load_time_now(t);
    c = wr_cyc;
    repeat (3) next_cycle();
    strobe_samples(2'b01, 4);
    collect_packet();
    verify_packet("timestamp", 0, 8'd4, 1'b1, t + 64'(stb_cyc - c - 1));
  endtask

  // PPS raised in cycle d is detected in d+1, and P appears in d+2
  task automatic test_pps();
    vita_time_t b;
    vita_time_t p;
    int         c;
    int         d;
    b = {32'd0, $urandom};
    p = {$urandom, 32'd0};
    load_time_now(b);
    c = wr_cyc;
    set_write(SR_TIME_HI, p[63:32]);
    set_write(SR_TIME_LO, p[31:0]);
    set_write(SR_TIME_CTRL, 32'h2);
    d   = cyc;
    pps = 1'b1;
    repeat (3) next_cycle();
    pps = 1'b0;
    check_time("pps lastpps", b + 64'(d - c), lastpps);
    next_cycle();
    strobe_samples(2'b01, 4);
    collect_packet();
    verify_packet("pps timestamp", 0, 8'd4, 1'b1, p + 64'(stb_cyc - d - 2));
  endtask

  // Radio 0 sent every packet so far, so round robin starts at radio 1
  task automatic test_arbitration();
    int r;
    config_radio(0, 2);
    config_radio(1, 2);
    strobe_samples(2'b11, 4);
    r = 0;
    for (int k = 0; k < 4; k++) begin
      r = (r + 1) % NUM_RADIOS;
      collect_packet();
      verify_packet("arbitration", r, 8'd2, 1'b0, '0);
    end
    // Sequence restarts after a disable and enable
    disable_radio(1);
    set_write(radio_addr(1, SR_RX_ENABLE), 32'd1);
    strobe_samples(2'b10, 2);
    collect_packet();
    verify_packet("seq reset", 1, 8'd2, 1'b0, '0);
  endtask

  task automatic test_overflow();
    out_ready = 1'b0;
    config_radio(0, 4);
    strobe_samples(2'b01, FIFO_DEPTH + 3);
    check_bit("overflow set", 1'b1, overflow[0]);
    while (exp_q[0].size() > FIFO_DEPTH) begin
      void'(exp_q[0].pop_back());
    end
    out_ready = 1'b1;
    for (int k = 0; k < FIFO_DEPTH / 4; k++) begin
      collect_packet();
      verify_packet("overflow", 0, 8'd4, 1'b0, '0);
    end
    // Dropped samples must never come out as a further packet
    repeat (4) next_cycle();
    if (mon_q.size() != 0) begin
      report_failure("overflow: beats came out beyond the buffered samples");
    end
    disable_radio(0);
    check_bit("overflow cleared", 1'b0, overflow[0]);
  endtask

  initial begin
    #(TIMEOUT_NS);
    report_failure("Timeout: the tests did not finish in time");
  end

  initial begin
    void'($urandom(8552));
    ce_clk    = 1'b0;
    cyc       = 0;
    i_rst_n   = 1'b0;
    set_bus   = '0;
    pps       = 1'b0;
    rx        = '0;
    rx_stb    = '0;
    out_ready = 1'b1;
    for (int r = 0; r < NUM_RADIOS; r++) begin
      exp_seq[r] = '0;
    end
    repeat (2) @(posedge ce_clk);
    #1;
    i_rst_n = 1'b1;
    check_bit("reset tvalid", 1'b0, tvalid);
    check_bit("reset overflow", 1'b0, |overflow);

    test_single_packet();
    test_timestamp();
    test_pps();
    test_arbitration();
    test_overflow();

    $display("STATUS: PASS");
    $finish;
  end

endmodule

/* verification/pkt_arbiter_asserts.sv */
/*
 * Packet arbiter checks
 * Output handshake stability, packet atomicity, reset state and single ready
 */
`timescale 1ns/1ps

module pkt_arbiter_asserts (
  input logic                                   ce_clk,
  input logic                                   i_rst_n,
  input radio_pkg::stream_beat_t                o_beat,
  input logic                                   o_tvalid,
  input logic                                   i_tready,
  input logic [radio_pkg::NUM_RADIOS-1:0]       o_tready,
  input logic [radio_pkg::RADIO_IDX_W-1:0]      grant_idx
);

  logic mid_pkt;

  // High between the first beat and the tlast beat of a packet
  always_ff @(posedge ce_clk) begin
    if (!i_rst_n) begin
      mid_pkt <= 1'b0;
    end else if (o_tvalid && i_tready) begin
      mid_pkt <= !o_beat.tlast;
    end
  end

  a_stall_stable: assert property (@(posedge ce_clk) disable iff (!i_rst_n)
    o_tvalid && !i_tready |=> o_tvalid && $stable(o_beat))
    else $error("Output beat changed while stalled");

  a_grant_held: assert property (@(posedge ce_clk) disable iff (!i_rst_n)
    mid_pkt |-> $stable(grant_idx))
    else $error("Grant moved in the middle of a packet");

  a_reset_idle: assert property (@(posedge ce_clk)
    !i_rst_n |=> !o_tvalid)
    else $error("Output valid high after a reset cycle");

  a_one_ready: assert property (@(posedge ce_clk) disable iff (!i_rst_n)
    $onehot0(o_tready))
    else $error("More than one input ready at once");

endmodule

bind pkt_arbiter pkt_arbiter_asserts arbiter_checks (
  .ce_clk    (ce_clk),
  .i_rst_n   (i_rst_n),
  .o_beat    (o_beat),
  .o_tvalid  (o_tvalid),
  .i_tready  (i_tready),
  .o_tready  (o_tready),
  .grant_idx (grant_idx)
);

/* design/radio_block.sv */
/*
 * Radio block top level
 * Timekeeper, one receive core per radio and the output packet arbiter
 */
`timescale 1ns/1ps

module radio_block (
  input  logic                                           ce_clk,
  input  logic                                           i_rst_n,
  input  radio_pkg::settings_bus_t                       i_set,
  input  logic                                           i_pps,
  input  radio_pkg::sample_t [radio_pkg::NUM_RADIOS-1:0] i_rx,
  input  logic [radio_pkg::NUM_RADIOS-1:0]               i_rx_stb,
  input  logic                                           i_o_tready,
  output radio_pkg::stream_beat_t                        o_beat,
  output logic                                           o_tvalid,
  output radio_pkg::vita_time_t                          o_vita_time_lastpps,
  output logic [radio_pkg::NUM_RADIOS-1:0]               o_rx_overflow
);

  import radio_pkg::*;

  vita_time_t                     vita_time;
  stream_beat_t [NUM_RADIOS-1:0]  core_beats;
  logic         [NUM_RADIOS-1:0]  core_tvalid;
  logic         [NUM_RADIOS-1:0]  core_tready;

  ////////////////////////////////////////////////////////////////////////////
  // Time
  ////////////////////////////////////////////////////////////////////////////
  timekeeper timekeeper (
    .ce_clk              (ce_clk),
    .i_rst_n             (i_rst_n),
    .i_set               (i_set),
    .i_pps               (i_pps),
    .o_vita_time         (vita_time),
    .o_vita_time_lastpps (o_vita_time_lastpps)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Radio cores
  ////////////////////////////////////////////////////////////////////////////
  for (genvar i = 0; i < NUM_RADIOS; i++) begin : gen_radio
    radio_core #(
      .RADIO_NUM (i)
    ) radio_core (
      .ce_clk      (ce_clk),
      .i_rst_n     (i_rst_n),
      .i_set       (i_set),
      .i_vita_time (vita_time),
      .i_rx        (i_rx[i]),
      .i_rx_stb    (i_rx_stb[i]),
      .o_beat      (core_beats[i]),
      .o_tvalid    (core_tvalid[i]),
      .i_tready    (core_tready[i]),
      .o_overflow  (o_rx_overflow[i])
    );
  end

  // Merge onto the single output stream
  pkt_arbiter pkt_arbiter (
    .ce_clk   (ce_clk),
    .i_rst_n  (i_rst_n),
    .i_beats  (core_beats),
    .i_tvalid (core_tvalid),
    .o_tready (core_tready),
    .o_beat   (o_beat),
    .o_tvalid (o_tvalid),
    .i_tready (i_o_tready)
  );

endmodule

/* design/pkt_arbiter.sv */
/*
 * Packet arbiter
 * Round-robin merge of the radio streams, grant held for a whole packet
 */
`timescale 1ns/1ps

module pkt_arbiter (
  input  logic                                             ce_clk,
  input  logic                                             i_rst_n,
  input  radio_pkg::stream_beat_t [radio_pkg::NUM_RADIOS-1:0] i_beats,
  input  logic [radio_pkg::NUM_RADIOS-1:0]                 i_tvalid,
  output logic [radio_pkg::NUM_RADIOS-1:0]                 o_tready,
  output radio_pkg::stream_beat_t                          o_beat,
  output logic                                             o_tvalid,
  input  logic                                             i_tready
);

  import radio_pkg::*;

  typedef enum logic {
    IDLE,
    BUSY
  } state_t;

  state_t                 state;
  logic [RADIO_IDX_W-1:0] grant_idx;
  logic [RADIO_IDX_W-1:0] last_idx;
  logic [RADIO_IDX_W-1:0] next_idx;
  logic                   found;

  // Search starts one past the last granted radio
  always_comb begin
    int cand;
    found    = 1'b0;
    next_idx = last_idx;
    for (int off = 1; off <= NUM_RADIOS; off++) begin
      cand = int'(last_idx) + off;
      if (cand >= NUM_RADIOS) begin
        cand = cand - NUM_RADIOS;
      end
      if (!found && i_tvalid[cand]) begin
        found    = 1'b1;
        next_idx = RADIO_IDX_W'(cand);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output mux with no added latency
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    o_tready = '0;
    o_beat   = i_beats[grant_idx];
    o_tvalid = 1'b0;
    if (state == BUSY) begin
      o_tvalid            = i_tvalid[grant_idx];
      o_tready[grant_idx] = i_tready;
    end
  end

  always_ff @(posedge ce_clk) begin
    if (!i_rst_n) begin
      state     <= IDLE;
      grant_idx <= '0;
      // Radio 0 wins the first round
      last_idx  <= RADIO_IDX_W'(NUM_RADIOS - 1);
    end else begin
      case (state)
        IDLE: begin
          if (found) begin
            grant_idx <= next_idx;
            state     <= BUSY;
          end
        end
        BUSY: begin
          if (o_tvalid && i_tready && o_beat.tlast) begin
            last_idx <= grant_idx;
            state    <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

/* radio_core/radio_core.sv */
/*
 * Radio core
 * Settings decode for one radio and receive framer: header, timestamp, samples
 */
`timescale 1ns/1ps

module radio_core #(
  parameter int RADIO_NUM = 0
) (
  input  logic                     ce_clk,
  input  logic                     i_rst_n,
  input  radio_pkg::settings_bus_t i_set,
  input  radio_pkg::vita_time_t    i_vita_time,
  input  radio_pkg::sample_t       i_rx,
  input  logic                     i_rx_stb,
  output radio_pkg::stream_beat_t  o_beat,
  output logic                     o_tvalid,
  input  logic                     i_tready,
  output logic                     o_overflow
);

  import radio_pkg::*;

  localparam set_addr_t MY_BASE = set_addr_t'(SR_RADIO_BASE + RADIO_ADDR_SPAN * RADIO_NUM);

  typedef enum logic [1:0] {
    IDLE,
    HEADER,
    TIME,
    SAMPLES
  } state_t;

  state_t     state;
  logic       enable;
  spp_t       spp;
  spp_t       pkt_spp;
  seqnum_t    seqnum;
  seqnum_t    pkt_seq;
  spp_t       sample_cnt;
  logic       hit_enable;
  logic       hit_spp;
  logic       clear_stats;
  logic       fifo_rd;
  logic       fifo_empty;
  sample_t    fifo_data;
  vita_time_t fifo_time;
  logic       xfer;
  logic       last_sample;
  word_t      hdr_word;

  ////////////////////////////////////////////////////////////////////////////
  // Settings decode
  ////////////////////////////////////////////////////////////////////////////
  assign hit_enable  = i_set.stb && (i_set.addr == set_addr_t'(MY_BASE + SR_RX_ENABLE));
  assign hit_spp     = i_set.stb && (i_set.addr == set_addr_t'(MY_BASE + SR_RX_SPP));
  assign clear_stats = hit_enable && !i_set.data[0];

  always_ff @(posedge ce_clk) begin
    if (!i_rst_n) begin
      enable <= 1'b0;
      spp    <= spp_t'(1);
    end else begin
      if (hit_enable) begin
        enable <= i_set.data[0];
      end
      // Zero would give an empty packet, run it as one sample
      if (hit_spp) begin
        spp <= (i_set.data[7:0] == '0) ? spp_t'(1) : spp_t'(i_set.data[7:0]);
      end
    end
  end

  rx_sample_fifo rx_sample_fifo (
    .ce_clk     (ce_clk),
    .i_rst_n    (i_rst_n),
    .i_clear    (clear_stats),
    .i_wr_data  (i_rx),
    .i_wr_time  (i_vita_time),
    .i_wr_en    (i_rx_stb && enable),
    .i_rd_en    (fifo_rd),
    .o_rd_data  (fifo_data),
    .o_rd_time  (fifo_time),
    .o_empty    (fifo_empty),
    .o_overflow (o_overflow)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Framer
  ////////////////////////////////////////////////////////////////////////////
  assign xfer        = o_tvalid && i_tready;
  assign last_sample = (sample_cnt == pkt_spp - 1'b1);
  assign fifo_rd     = (state == SAMPLES) && xfer;

  always_comb begin
    hdr_word = '0;
    hdr_word[HDR_RADIO_LSB +: 8] = 8'(RADIO_NUM);
    hdr_word[HDR_SEQ_LSB +: 8]   = pkt_seq;
    hdr_word[HDR_SPP_LSB +: 8]   = pkt_spp;
  end

  always_comb begin
    o_tvalid     = 1'b0;
    o_beat.tdata = hdr_word;
    o_beat.tlast = 1'b0;
    case (state)
      HEADER: begin
        o_tvalid = 1'b1;
      end
      TIME: begin
        // Head of the FIFO is the packet's first sample
        o_tvalid     = 1'b1;
        o_beat.tdata = fifo_time;
      end
      SAMPLES: begin
        o_tvalid     = !fifo_empty;
        o_beat.tdata = {32'd0, fifo_data};
        o_beat.tlast = last_sample;
      end
      default: begin
        o_tvalid = 1'b0;
      end
    endcase
  end

  always_ff @(posedge ce_clk) begin
    if (!i_rst_n) begin
      state      <= IDLE;
      seqnum     <= '0;
      pkt_seq    <= '0;
      pkt_spp    <= spp_t'(1);
      sample_cnt <= '0;
    end else begin
      if (clear_stats) begin
        seqnum <= '0;
      end else if (fifo_rd && last_sample) begin
        seqnum <= seqnum + 1'b1;
      end

      case (state)
        IDLE: begin
          if (!fifo_empty) begin
            pkt_seq <= seqnum;
            pkt_spp <= spp;
            state   <= HEADER;
          end
        end
        HEADER: begin
          if (xfer) begin
            state <= TIME;
          end
        end
        TIME: begin
          if (xfer) begin
            sample_cnt <= '0;
            state      <= SAMPLES;
          end
        end
        SAMPLES: begin
          if (xfer) begin
            sample_cnt <= sample_cnt + 1'b1;
            if (last_sample) begin
              state <= IDLE;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

/* radio_core/rx_sample_fifo.sv */
/*
 * Receive sample FIFO
 * Holds strobed samples with their time, drops writes when full and flags it
 */
`timescale 1ns/1ps

module rx_sample_fifo (
  input  logic                  ce_clk,
  input  logic                  i_rst_n,
  input  logic                  i_clear,
  input  radio_pkg::sample_t    i_wr_data,
  input  radio_pkg::vita_time_t i_wr_time,
  input  logic                  i_wr_en,
  input  logic                  i_rd_en,
  output radio_pkg::sample_t    o_rd_data,
  output radio_pkg::vita_time_t o_rd_time,
  output logic                  o_empty,
  output logic                  o_overflow
);

  import radio_pkg::*;

  typedef struct packed {
    vita_time_t stamp;
    sample_t    sample;
  } entry_t;

  entry_t             mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic [FIFO_AW:0]   count;
  logic               full;
  logic               do_wr;
  logic               do_rd;
  logic               overflow;

  assign full    = (count == (FIFO_AW+1)'(FIFO_DEPTH));
  assign o_empty = (count == '0);
  assign do_wr   = i_wr_en && !full;
  assign do_rd   = i_rd_en && !o_empty;

  // Storage
  always_ff @(posedge ce_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= '{stamp: i_wr_time, sample: i_wr_data};
    end
  end

  always_ff @(posedge ce_clk) begin
    if (!i_rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase

      // Sticky until cleared
      // A drop in the same cycle as a clear still counts
      if (i_wr_en && full) begin
        overflow <= 1'b1;
      end else if (i_clear) begin
        overflow <= 1'b0;
      end
    end
  end

  // Head entry is visible without a read
  assign o_rd_data  = mem[rd_ptr].sample;
  assign o_rd_time  = mem[rd_ptr].stamp;
  assign o_overflow = overflow;

endmodule

/* design/timekeeper.sv */
/*
 * Timekeeper
 * Sample-clock time counter, loaded now or at the next PPS, with last-PPS latch
 */
`timescale 1ns/1ps

module timekeeper (
  input  logic                     ce_clk,
  input  logic                     i_rst_n,
  input  radio_pkg::settings_bus_t i_set,
  input  logic                     i_pps,
  output radio_pkg::vita_time_t    o_vita_time,
  output radio_pkg::vita_time_t    o_vita_time_lastpps
);

  import radio_pkg::*;

  set_data_t  pending_hi;
  set_data_t  pending_lo;
  vita_time_t pending;
  vita_time_t vita_time;
  vita_time_t vita_time_lastpps;
  logic       pps_q;
  logic       pps_q_d;
  logic       pps_edge;
  logic       armed;
  logic       load_now;
  logic       arm_pps;
  logic       ctrl_wr;

  assign ctrl_wr  = i_set.stb && (i_set.addr == SR_TIME_CTRL);
  assign load_now = ctrl_wr && i_set.data[TIME_CTRL_NOW_BIT];
  assign arm_pps  = ctrl_wr && i_set.data[TIME_CTRL_PPS_BIT];
  assign pending  = {pending_hi, pending_lo};

  // Edge shows up one cycle after PPS is first sampled high
  assign pps_edge = pps_q && !pps_q_d;

  // Pending time halves
  always_ff @(posedge ce_clk) begin
    if (i_set.stb && (i_set.addr == SR_TIME_HI)) begin
      pending_hi <= i_set.data;
    end
    if (i_set.stb && (i_set.addr == SR_TIME_LO)) begin
      pending_lo <= i_set.data;
    end
  end

  always_ff @(posedge ce_clk) begin
    if (!i_rst_n) begin
      vita_time         <= '0;
      vita_time_lastpps <= '0;
      armed             <= 1'b0;
      pps_q             <= 1'b0;
      pps_q_d           <= 1'b0;
    end else begin
      pps_q   <= i_pps;
      pps_q_d <= pps_q;

      // Immediate load wins over a PPS-timed one
      if (load_now || (pps_edge && armed)) begin
        vita_time <= pending;
      end else begin
        vita_time <= vita_time + 64'd1;
      end

      if (pps_edge) begin
        vita_time_lastpps <= vita_time;
      end

      if (arm_pps) begin
        armed <= 1'b1;
      end else if (pps_edge) begin
        armed <= 1'b0;
      end
    end
  end

  assign o_vita_time         = vita_time;
  assign o_vita_time_lastpps = vita_time_lastpps;

endmodule

/* common/radio_pkg.sv */
/*
 * Radio block shared definitions
 * Widths, bus structs, register map and header layout used by every block
 */

package radio_pkg;

  // Block sizing
  localparam int NUM_RADIOS  = 2;
  localparam int RADIO_IDX_W = (NUM_RADIOS > 1) ? $clog2(NUM_RADIOS) : 1;
  localparam int FIFO_DEPTH  = 16;
  localparam int FIFO_AW     = $clog2(FIFO_DEPTH);

  // Widths that carry a meaning
  typedef logic [31:0] sample_t;
  typedef logic [63:0] word_t;
  typedef logic [63:0] vita_time_t;
  typedef logic [7:0]  set_addr_t;
  typedef logic [31:0] set_data_t;
  typedef logic [7:0]  spp_t;
  typedef logic [7:0]  seqnum_t;

  // Settings bus carrying one write per cycle with stb high
  typedef struct packed {
    logic      stb;
    set_addr_t addr;
    set_data_t data;
  } settings_bus_t;

  // Stream beat with valid and ready travelling beside it
  typedef struct packed {
    word_t tdata;
    logic  tlast;
  } stream_beat_t;

  ////////////////////////////////////////////////////////////////////////////
  // Register map
  ////////////////////////////////////////////////////////////////////////////
  localparam set_addr_t SR_TIME_HI   = 8'd128;
  localparam set_addr_t SR_TIME_LO   = 8'd129;
  localparam set_addr_t SR_TIME_CTRL = 8'd130;

  // Time control bits
  localparam int TIME_CTRL_NOW_BIT = 0;
  localparam int TIME_CTRL_PPS_BIT = 1;

  // Each radio owns a span of addresses starting here
  localparam set_addr_t SR_RADIO_BASE   = 8'd136;
  localparam int        RADIO_ADDR_SPAN = 8;

  // Offsets inside one radio span
  localparam int SR_RX_ENABLE = 0;
  localparam int SR_RX_SPP    = 1;

  // Header word field positions
  localparam int HDR_RADIO_LSB = 56;
  localparam int HDR_SEQ_LSB   = 48;
  localparam int HDR_SPP_LSB   = 40;

endpackage
